// File: hw/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

  // Data and address word
  typedef logic [15:0] word_t;

  // Register number
  typedef logic [3:0] reg_addr_t;

  // Opcodes where the missing codes run as no-ops
  typedef enum logic [3:0] {
    OP_ADD = 4'b0000,
    OP_SUB = 4'b0001,
    OP_XOR = 4'b0010,
    OP_SLL = 4'b0100,
    OP_SRA = 4'b0101,
    OP_ROR = 4'b0110,
    OP_LW  = 4'b1000,
    OP_SW  = 4'b1001,
    OP_LLB = 4'b1010,
    OP_LHB = 4'b1011,
    OP_B   = 4'b1100,
    OP_HLT = 4'b1111
  } opcode_e;

  // Branch conditions on the stored Z, V, N flags
  typedef enum logic [2:0] {
    BR_NEQ    = 3'b000,
    BR_EQ     = 3'b001,
    BR_GT     = 3'b010,
    BR_LT     = 3'b011,
    BR_GTE    = 3'b100,
    BR_LTE    = 3'b101,
    BR_OVFL   = 3'b110,
    BR_UNCOND = 3'b111
  } br_cond_e;

  localparam int NUM_REGS = 16;
  localparam word_t PC_STEP = 16'd2;

  // Instruction field positions
  localparam int OPCODE_HI = 15;
  localparam int OPCODE_LO = 12;
  localparam int RD_HI = 11;
  localparam int RD_LO = 8;
  localparam int RS_HI = 7;
  localparam int RS_LO = 4;
  localparam int RT_HI = 3;
  localparam int RT_LO = 0;
  localparam int IMM4_HI = 3;
  localparam int IMM8_HI = 7;
  localparam int IMM9_HI = 8;
  localparam int IMM_LO = 0;
  localparam int COND_HI = 11;
  localparam int COND_LO = 9;

endpackage

`default_nettype wire

// File: hw/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

  // Sequencer states for one instruction at a time
  typedef enum logic [2:0] {
    RESET_IDLE,
    FETCH,
    FETCH_RELEASE,
    EXECUTE,
    MEM_ACCESS,
    MEM_RELEASE,
    HALTED
  } ctrl_state_e;

  // Register writeback source
  typedef enum logic {
    WB_ALU,
    WB_MEM
  } wb_sel_e;

endpackage

`default_nettype wire

// File: hw/cpu_control.sv
`default_nettype none

module cpu_control
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  opcode_e opcode,
  input  logic    mem_ack,
  output logic    mem_req,
  output logic    mem_we,
  output logic    ir_load,
  output logic    pc_load,
  output logic    data_phase,
  output logic    reg_we,
  output wb_sel_e wb_sel,
  output logic    flag_we_z,
  output logic    flag_we_vn,
  output logic    br_en,
  output logic    hlt
);

  ctrl_state_e state;
  ctrl_state_e next_state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RESET_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    mem_req = 1'b0;
    mem_we = 1'b0;
    ir_load = 1'b0;
    pc_load = 1'b0;
    data_phase = 1'b0;
    reg_we = 1'b0;
    wb_sel = WB_ALU;
    flag_we_z = 1'b0;
    flag_we_vn = 1'b0;
    br_en = 1'b0;
    hlt = 1'b0;
    case (state)
      RESET_IDLE: begin
        next_state = FETCH;
      end
      FETCH: begin
        // Instruction read at the PC
        mem_req = 1'b1;
        if (mem_ack) begin
          ir_load = 1'b1;
          next_state = FETCH_RELEASE;
        end
      end
      FETCH_RELEASE: begin
        // Wait for ack to drop
        if (!mem_ack) begin
          next_state = EXECUTE;
        end
      end
      EXECUTE: begin
        // Every instruction but HLT advances the PC here
        pc_load = 1'b1;
        next_state = FETCH;
        case (opcode)
          OP_ADD, OP_SUB: begin
            reg_we = 1'b1;
            flag_we_z = 1'b1;
            flag_we_vn = 1'b1;
          end
          OP_XOR, OP_SLL, OP_SRA, OP_ROR: begin
            reg_we = 1'b1;
            flag_we_z = 1'b1;
          end
          OP_LLB, OP_LHB: begin
            reg_we = 1'b1;
          end
          OP_LW, OP_SW: begin
            next_state = MEM_ACCESS;
          end
          OP_B: begin
            br_en = 1'b1;
          end
          OP_HLT: begin
            // PC stays on the HLT address
            pc_load = 1'b0;
            next_state = HALTED;
          end
          default: begin
          end
        endcase
      end
      MEM_ACCESS: begin
        mem_req = 1'b1;
        data_phase = 1'b1;
        mem_we = (opcode == OP_SW);
        if (mem_ack) begin
          // Load data is valid with ack
          if (opcode == OP_LW) begin
            reg_we = 1'b1;
            wb_sel = WB_MEM;
          end
          next_state = MEM_RELEASE;
        end
      end
      MEM_RELEASE: begin
        if (!mem_ack) begin
          next_state = FETCH;
        end
      end
      HALTED: begin
        hlt = 1'b1;
      end
      default: begin
        next_state = RESET_IDLE;
      end
    endcase
  end

  // Request held until acknowledged
  req_held_until_ack: assert property (@(posedge clk) disable iff (rst)
    $fell(mem_req) |-> $past(mem_ack))
    else $error("mem_req dropped before mem_ack");

  // New request only after ack seen low
  no_req_during_ack: assert property (@(posedge clk) disable iff (rst)
    $rose(mem_req) |-> !$past(mem_ack))
    else $error("mem_req raised while mem_ack high");

  // Write enable steady for the whole request
  we_stable_in_req: assert property (@(posedge clk) disable iff (rst)
    mem_req && $past(mem_req) |-> $stable(mem_we))
    else $error("mem_we changed during a request");

endmodule

`default_nettype wire

// File: hw/fetch_decode.sv
`default_nettype none

module fetch_decode
  import cpu_isa_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      ir_load,
  input  logic      pc_load,
  input  logic      data_phase,
  input  logic      br_taken,
  input  word_t     mem_rdata,
  input  word_t     data_addr,
  output word_t     mem_addr,
  output word_t     pc,
  output opcode_e   opcode,
  output reg_addr_t rs_addr,
  output reg_addr_t rt_addr,
  output reg_addr_t rd_addr,
  output logic [7:0] imm8,
  output br_cond_e  br_cond
);

  word_t ir;
  word_t pc_next;
  word_t br_target;
  logic [8:0] imm9;

  // Sequential PC and branch target both wrap
  assign pc_next = pc + PC_STEP;
  assign imm9 = ir[IMM9_HI:IMM_LO];
  assign br_target = pc_next + {{6{imm9[8]}}, imm9, 1'b0};

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (pc_load) begin
      pc <= br_taken ? br_target : pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ir <= '0;
    end else if (ir_load) begin
      ir <= mem_rdata;
    end
  end

  // Field split
  assign opcode = opcode_e'(ir[OPCODE_HI:OPCODE_LO]);
  assign rd_addr = ir[RD_HI:RD_LO];
  assign rs_addr = ir[RS_HI:RS_LO];
  assign imm8 = ir[IMM8_HI:IMM_LO];
  assign br_cond = br_cond_e'(ir[COND_HI:COND_LO]);

  // SW source and LLB/LHB merge base both sit in the Rd field
  assign rt_addr = (opcode == OP_SW || opcode == OP_LLB || opcode == OP_LHB) ?
                   ir[RD_HI:RD_LO] : ir[RT_HI:RT_LO];

  // Data address in the memory phase and the PC otherwise
  assign mem_addr = data_phase ? data_addr : pc;

endmodule

`default_nettype wire

// File: hw/register_file.sv
`default_nettype none

module register_file
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rs_addr,
  input  reg_addr_t rt_addr,
  input  reg_addr_t rd_addr,
  input  logic      reg_we,
  input  wb_sel_e   wb_sel,
  input  word_t     alu_result,
  input  word_t     mem_rdata,
  output word_t     rs_data,
  output word_t     rt_data
);

  word_t regs [NUM_REGS];
  word_t wr_data;

  // Writeback source
  assign wr_data = (wb_sel == WB_MEM) ? mem_rdata : alu_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_we && rd_addr != '0) begin
      regs[rd_addr] <= wr_data;
    end
  end

  // r0 is hardwired to zero
  assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
  assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// File: hw/alu.sv
`default_nettype none

module alu
  import cpu_isa_pkg::*;
(
  input  opcode_e    opcode,
  input  word_t      a,
  input  word_t      b,
  input  logic [7:0] imm8,
  output word_t      result,
  output logic       z,
  output logic       v,
  output logic       n
);

  word_t sum;
  word_t diff;
  logic sum_ovf;
  logic diff_ovf;
  logic [3:0] imm4;
  logic [31:0] rot;
  word_t ls_addr;

  assign imm4 = imm8[IMM4_HI:IMM_LO];

  // Signed overflow from the operand and result signs
  assign sum = a + b;
  assign diff = a - b;
  assign sum_ovf = (a[15] == b[15]) && (sum[15] != a[15]);
  assign diff_ovf = (a[15] != b[15]) && (diff[15] != a[15]);

  // Rotate via a doubled word
  assign rot = {a, a} >> imm4;

  // Halfword aligned base plus scaled offset
  assign ls_addr = (a & 16'hFFFE) + {{11{imm4[3]}}, imm4, 1'b0};

  always_comb begin
    result = '0;
    v = 1'b0;
    case (opcode)
      OP_ADD: begin
        // Clamp toward the operand sign
        result = sum_ovf ? (a[15] ? 16'h8000 : 16'h7FFF) : sum;
        v = sum_ovf;
      end
      OP_SUB: begin
        result = diff_ovf ? (a[15] ? 16'h8000 : 16'h7FFF) : diff;
        v = diff_ovf;
      end
      OP_XOR: result = a ^ b;
      OP_SLL: result = a << imm4;
      OP_SRA: result = word_t'($signed(a) >>> imm4);
      OP_ROR: result = rot[15:0];
      OP_LW, OP_SW: result = ls_addr;
      // Byte merge into the Rd value
      OP_LLB: result = {b[15:8], imm8};
      OP_LHB: result = {imm8, b[7:0]};
      default: begin
      end
    endcase
  end

  assign z = (result == '0);
  assign n = result[15];

endmodule

`default_nettype wire

// File: hw/branch_unit.sv
`default_nettype none

module branch_unit
  import cpu_isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     z,
  input  logic     v,
  input  logic     n,
  input  logic     flag_we_z,
  input  logic     flag_we_vn,
  input  logic     br_en,
  input  br_cond_e br_cond,
  output logic     br_taken
);

  logic z_q;
  logic v_q;
  logic n_q;
  logic cond_met;

  // Z written apart from V and N
  always_ff @(posedge clk) begin
    if (rst) begin
      z_q <= 1'b0;
      v_q <= 1'b0;
      n_q <= 1'b0;
    end else begin
      if (flag_we_z) begin
        z_q <= z;
      end
      if (flag_we_vn) begin
        v_q <= v;
        n_q <= n;
      end
    end
  end

  always_comb begin
    case (br_cond)
      BR_NEQ:  cond_met = !z_q;
      BR_EQ:   cond_met = z_q;
      BR_GT:   cond_met = !z_q && !n_q;
      BR_LT:   cond_met = n_q;
      BR_GTE:  cond_met = z_q || !n_q;
      BR_LTE:  cond_met = z_q || n_q;
      BR_OVFL: cond_met = v_q;
      default: cond_met = 1'b1;
    endcase
  end

  assign br_taken = br_en && cond_met;

endmodule

`default_nettype wire

// File: hw/cpu.sv
`default_nettype none

module cpu
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  output logic  mem_req,
  output logic  mem_we,
  output word_t mem_addr,
  output word_t mem_wdata,
  input  logic  mem_ack,
  input  word_t mem_rdata,
  output logic  hlt,
  output word_t pc
);

  // Control strobes
  logic ir_load;
  logic pc_load;
  logic data_phase;
  logic reg_we;
  wb_sel_e wb_sel;
  logic flag_we_z;
  logic flag_we_vn;
  logic br_en;
  logic br_taken;

  // Decode and datapath
  opcode_e opcode;
  reg_addr_t rs_addr;
  reg_addr_t rt_addr;
  reg_addr_t rd_addr;
  logic [7:0] imm8;
  br_cond_e br_cond;
  word_t rs_data;
  word_t alu_result;
  logic z;
  logic v;
  logic n;

  cpu_control i_control (
    .clk(clk), .rst(rst), .opcode(opcode), .mem_ack(mem_ack),
    .mem_req(mem_req), .mem_we(mem_we), .ir_load(ir_load), .pc_load(pc_load),
    .data_phase(data_phase), .reg_we(reg_we), .wb_sel(wb_sel),
    .flag_we_z(flag_we_z), .flag_we_vn(flag_we_vn), .br_en(br_en), .hlt(hlt)
  );

  fetch_decode i_fetch_decode (
    .clk(clk), .rst(rst), .ir_load(ir_load), .pc_load(pc_load),
    .data_phase(data_phase), .br_taken(br_taken), .mem_rdata(mem_rdata),
    .data_addr(alu_result), .mem_addr(mem_addr), .pc(pc), .opcode(opcode),
    .rs_addr(rs_addr), .rt_addr(rt_addr), .rd_addr(rd_addr), .imm8(imm8),
    .br_cond(br_cond)
  );

  // Read port 2 doubles as store data
  register_file i_register_file (
    .clk(clk), .rst(rst), .rs_addr(rs_addr), .rt_addr(rt_addr), .rd_addr(rd_addr),
    .reg_we(reg_we), .wb_sel(wb_sel), .alu_result(alu_result), .mem_rdata(mem_rdata),
    .rs_data(rs_data), .rt_data(mem_wdata)
  );

  alu i_alu (
    .opcode(opcode), .a(rs_data), .b(mem_wdata), .imm8(imm8),
    .result(alu_result), .z(z), .v(v), .n(n)
  );

  branch_unit i_branch_unit (
    .clk(clk), .rst(rst), .z(z), .v(v), .n(n), .flag_we_z(flag_we_z),
    .flag_we_vn(flag_we_vn), .br_en(br_en), .br_cond(br_cond), .br_taken(br_taken)
  );

endmodule

`default_nettype wire

// File: test/cpu_ref_model.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// Unified memory image indexed by address bits 15:1
word_t mem [MEM_WORDS];
word_t ref_mem [MEM_WORDS];
word_t ref_regs [NUM_REGS];
logic ref_z;
logic ref_v;
logic ref_n;
word_t exp_addr_q [$];
word_t exp_data_q [$];
word_t exp_halt_pc;
logic [14:0] wp;

function automatic int pick(int n);
  return $unsigned($random(seed)) % n;
endfunction

function automatic logic [3:0] pick_field(int n);
  return 4'(pick(n));
endfunction

// Picks r0 or r2..r15 because r1 holds the data pointer
function automatic reg_addr_t pick_dest();
  logic [3:0] r;
  r = pick_field(15);
  return (r == 4'd0) ? 4'd0 : r + 4'd1;
endfunction

function automatic void emit(word_t w);
  mem[wp] = w;
  wp = wp + 15'd1;
endfunction

// Odd or even base pointer in the data region
function automatic void emit_base_setup();
  emit({OP_LLB, 4'd1, 8'(pick(256))});
  emit({OP_LHB, 4'd1, 8'h40});
endfunction

function automatic void emit_store();
  emit({OP_SW, pick_field(16), 4'd1, pick_field(16)});
endfunction

function automatic void build_program();
  opcode_e alu_ops [6] = '{OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRA, OP_ROR};
  logic [3:0] noops [4] = '{4'h3, 4'h7, 4'hD, 4'hE};
  reg_addr_t d;
  int skip;
  int n_branch;
  // Background data with every word distinct
  for (int i = 0; i < MEM_WORDS; i++) begin
    mem[15'(i)] = 16'(i * 40503) ^ 16'(i >> 7);
  end
  wp = '0;
  n_branch = 0;
  emit_base_setup();
  for (int blk = 0; blk < PROG_BLOCKS; blk++) begin
    d = pick_dest();
    case (pick(5))
      0: begin
        // LLB alone keeps the old high byte
        emit({OP_LLB, d, 8'(pick(256))});
        if (pick(2) == 0) begin
          emit({OP_LHB, d, 8'(pick(256))});
        end
        emit({OP_SW, d, 4'd1, pick_field(16)});
      end
      1: begin
        emit({alu_ops[3'(pick(6))], d, pick_field(16), pick_field(16)});
        emit({OP_SW, d, 4'd1, pick_field(16)});
      end
      2: begin
        emit_base_setup();
        emit({OP_LW, d, 4'd1, pick_field(16)});
        emit({OP_SW, d, 4'd1, pick_field(16)});
      end
      3: begin
        // Forward branches taking the conditions in turn
        skip = pick(4);
        emit({OP_B, 3'(n_branch), 9'(skip)});
        n_branch++;
        for (int j = 0; j <= skip; j++) begin
          emit_store();
        end
      end
      default: begin
        emit({noops[2'(pick(4))], 12'(pick(4096))});
      end
    endcase
  end
  emit({OP_HLT, 12'h000});
endfunction

function automatic word_t read_reg(reg_addr_t r);
  return (r == 4'd0) ? 16'h0000 : ref_regs[r];
endfunction

function automatic void write_reg(reg_addr_t r, word_t val);
  if (r != 4'd0) begin
    ref_regs[r] = val;
  end
endfunction

function automatic word_t data_address(word_t base, logic [3:0] off);
  return {base[15:1], 1'b0} + {{11{off[3]}}, off, 1'b0};
endfunction

// Clamp a 17 bit signed sum into the 16 bit range
function automatic void write_arith(reg_addr_t rd, logic signed [16:0] wide);
  word_t res;
  if (wide > 17'sd32767) begin
    res = 16'h7FFF;
    ref_v = 1'b1;
  end else if (wide < -17'sd32768) begin
    res = 16'h8000;
    ref_v = 1'b1;
  end else begin
    res = wide[15:0];
    ref_v = 1'b0;
  end
  ref_z = (res == 16'h0000);
  ref_n = res[15];
  write_reg(rd, res);
endfunction

function automatic void write_logic(reg_addr_t rd, word_t res);
  ref_z = (res == 16'h0000);
  write_reg(rd, res);
endfunction

function automatic void run_reference();
  word_t pc_r;
  word_t next_pc;
  word_t instr;
  word_t a;
  word_t b;
  word_t d;
  word_t addr;
  logic [3:0] sh;
  logic taken;
  logic done;
  int steps;
  ref_regs = '{default: '0};
  ref_z = 1'b0;
  ref_v = 1'b0;
  ref_n = 1'b0;
  pc_r = '0;
  done = 1'b0;
  steps = 0;
  while (!done && steps < STEP_LIMIT) begin
    instr = ref_mem[pc_r[15:1]];
    a = read_reg(instr[7:4]);
    b = read_reg(instr[3:0]);
    d = read_reg(instr[11:8]);
    sh = instr[3:0];
    addr = data_address(a, instr[3:0]);
    next_pc = pc_r + 16'd2;
    case (opcode_e'(instr[15:12]))
      OP_ADD: write_arith(instr[11:8], $signed({a[15], a}) + $signed({b[15], b}));
      OP_SUB: write_arith(instr[11:8], $signed({a[15], a}) - $signed({b[15], b}));
      OP_XOR: write_logic(instr[11:8], a ^ b);
      OP_SLL: write_logic(instr[11:8], a << sh);
      // Logical shift with the sign copied into the vacated bits
      OP_SRA: write_logic(instr[11:8],
                          (a >> sh) | ({16{a[15]}} << (5'd16 - {1'b0, sh})));
      OP_ROR: write_logic(instr[11:8], (a >> sh) | (a << (5'd16 - {1'b0, sh})));
      OP_LW: write_reg(instr[11:8], ref_mem[addr[15:1]]);
      OP_SW: begin
        ref_mem[addr[15:1]] = d;
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(d);
      end
      OP_LLB: write_reg(instr[11:8], {d[15:8], instr[7:0]});
      OP_LHB: write_reg(instr[11:8], {instr[7:0], d[7:0]});
      OP_B: begin
        case (br_cond_e'(instr[11:9]))
          BR_NEQ: taken = !ref_z;
          BR_EQ: taken = ref_z;
          BR_GT: taken = !ref_z && !ref_n;
          BR_LT: taken = ref_n;
          BR_GTE: taken = ref_z || !ref_n;
          BR_LTE: taken = ref_z || ref_n;
          BR_OVFL: taken = ref_v;
          default: taken = 1'b1;
        endcase
        if (taken) begin
          next_pc = next_pc + {{6{instr[8]}}, instr[8:0], 1'b0};
        end
      end
      OP_HLT: begin
        exp_halt_pc = pc_r;
        next_pc = pc_r;
        done = 1'b1;
      end
      default: begin
      end
    endcase
    pc_r = next_pc;
    steps++;
  end
  if (!done) begin
    report_failure("Reference model never reached HLT");
  end
endfunction

`endif

// File: test/tb_cpu.sv
`default_nettype none

module tb_cpu
  import cpu_isa_pkg::*;
();

  localparam int MEM_WORDS = 32768;
  localparam int PROG_BLOCKS = 80;
  localparam int ACK_DELAY_MAX = 5;
  localparam int DROP_DELAY_MAX = 3;
  localparam int STEP_LIMIT = 4000;
  localparam int REQ_TIMEOUT = 20;
  localparam int HALT_TIMEOUT = 100000;
  localparam int HALT_QUIET = 50;

  // Memory model phases
  localparam int M_IDLE = 0;
  localparam int M_WAIT = 1;
  localparam int M_ACKED = 2;
  localparam int M_RELEASE = 3;

  logic clk;
  logic rst;
  logic mem_req;
  logic mem_we;
  word_t mem_addr;
  word_t mem_wdata;
  logic mem_ack;
  word_t mem_rdata;
  logic hlt;
  word_t pc;
  integer seed;

  int mem_phase;
  int mem_cnt;
  logic prev_req;
  word_t req_addr;
  word_t req_wdata;
  logic req_we;
  int cycles;

  function automatic void report_failure(string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endfunction

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Fail time %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      report_failure($sformatf("Fail time %0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  `include "cpu_ref_model.svh"

  // Next store in program order
  task automatic check_store();
    if (exp_addr_q.size() == 0) begin
      report_failure("The DUT wrote memory after the expected store trace had ended");
    end
    check_word("mem_addr on store", mem_addr, exp_addr_q.pop_front());
    check_word("mem_wdata on store", mem_wdata, exp_data_q.pop_front());
  endtask

  cpu i_dut (
    .clk(clk), .rst(rst), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata), .hlt(hlt), .pc(pc)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Memory with random ack and release delays
  always @(posedge clk) begin
    if (rst) begin
      mem_ack <= 1'b0;
      mem_phase <= M_IDLE;
      mem_cnt <= 0;
    end else begin
      case (mem_phase)
        M_IDLE: begin
          if (mem_req) begin
            mem_cnt <= pick(ACK_DELAY_MAX + 1);
            mem_phase <= M_WAIT;
          end
        end
        M_WAIT: begin
          if (mem_cnt == 0) begin
            // One access per request
            if (mem_we) begin
              mem[mem_addr[15:1]] = mem_wdata;
            end else begin
              mem_rdata <= mem[mem_addr[15:1]];
            end
            mem_ack <= 1'b1;
            mem_phase <= M_ACKED;
          end else begin
            mem_cnt <= mem_cnt - 1;
          end
        end
        M_ACKED: begin
          if (!mem_req) begin
            mem_cnt <= pick(DROP_DELAY_MAX + 1);
            mem_phase <= M_RELEASE;
          end
        end
        default: begin
          if (mem_cnt == 0) begin
            mem_ack <= 1'b0;
            mem_phase <= M_IDLE;
          end else begin
            mem_cnt <= mem_cnt - 1;
          end
        end
      endcase
    end
  end

  // Request protocol and store trace
  always @(posedge clk) begin
    if (rst) begin
      prev_req <= 1'b0;
    end else begin
      if (mem_req && !prev_req) begin
        if (mem_ack) begin
          report_failure("A request started while mem_ack was still high");
        end
        req_addr <= mem_addr;
        req_wdata <= mem_wdata;
        req_we <= mem_we;
        if (mem_we) begin
          check_store();
        end
      end else if (mem_req) begin
        // Held request must not move
        check_word("mem_addr", mem_addr, req_addr);
        check_bit("mem_we", mem_we, req_we);
        if (req_we) begin
          check_word("mem_wdata", mem_wdata, req_wdata);
        end
      end
      prev_req <= mem_req;
    end
  end

  initial begin
    seed = 46336;
    rst <= 1'b1;
    mem_ack <= 1'b0;
    mem_rdata <= '0;
    build_program();
    ref_mem = mem;
    run_reference();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_bit("mem_req", mem_req, 1'b0);
    check_bit("mem_we", mem_we, 1'b0);
    check_bit("hlt", hlt, 1'b0);
    // First access is the fetch at 0
    cycles = 0;
    while (!mem_req) begin
      @(posedge clk);
      cycles++;
      if (cycles > REQ_TIMEOUT) begin
        report_failure("Timed out waiting for the first memory request");
      end
    end
    check_bit("mem_we", mem_we, 1'b0);
    check_word("mem_addr", mem_addr, 16'h0000);
    cycles = 0;
    while (!hlt) begin
      @(posedge clk);
      cycles++;
      if (cycles > HALT_TIMEOUT) begin
        report_failure("Timed out waiting for hlt");
      end
    end
    check_word("pc", pc, exp_halt_pc);
    if (exp_addr_q.size() != 0) begin
      report_failure("The DUT halted before all expected stores were seen");
    end
    repeat (HALT_QUIET) begin
      @(posedge clk);
      check_bit("mem_req", mem_req, 1'b0);
      check_bit("hlt", hlt, 1'b1);
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_word($sformatf("mem[%0d]", i), mem[15'(i)], ref_mem[15'(i)]);
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+test
hw/cpu_isa_pkg.sv
hw/cpu_ctrl_pkg.sv
hw/cpu_control.sv
hw/fetch_decode.sv
hw/register_file.sv
hw/alu.sv
hw/branch_unit.sv
hw/cpu.sv
test/tb_cpu.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build folder"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -f list.f --top-module tb_cpu -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_cpu)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
